// File: Bender.yml
package:
  name: residual_block

sources:
  - logic/residual_pkg.sv
  - logic/fork2.sv
  - logic/relu_branch.sv
  - logic/skip_fifo.sv
  - logic/join_add.sv
  - logic/residual_block.sv
  - target: simulation
    files:
      - sim/residual_block_checker.sv
      - sim/residual_block_tb.sv

// File: logic/fork2.sv
`timescale 1ns/100ps
`default_nettype none

module fork2 (
  input  logic                clk,
  input  logic                arst_n,
  input  residual_pkg::beat_t in_data,
  input  logic                in_valid,
  output logic                in_ready,
  output residual_pkg::beat_t act_data,
  output logic                act_valid,
  input  logic                act_ready,
  output residual_pkg::beat_t skip_data,
  output logic                skip_valid,
  input  logic                skip_ready
);

  // set once a branch has the current beat
  logic act_taken;
  logic skip_taken;

  // each branch done, either earlier or now
  logic act_done;
  logic skip_done;

  // same beat goes to both branches
  assign act_data  = in_data;
  assign skip_data = in_data;

  // offer only to branches still missing the beat
  assign act_valid  = in_valid & ~act_taken;
  assign skip_valid = in_valid & ~skip_taken;

  assign act_done  = act_taken | act_ready;
  assign skip_done = skip_taken | skip_ready;

  // upstream completes once both branches hold it
  assign in_ready = in_valid & act_done & skip_done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      act_taken  <= 1'b0;
      skip_taken <= 1'b0;
    end else if (in_ready) begin
      // beat retired, next one starts clean
      act_taken  <= 1'b0;
      skip_taken <= 1'b0;
    end else begin
      // remember early takers
      act_taken  <= act_taken | (act_valid & act_ready);
      skip_taken <= skip_taken | (skip_valid & skip_ready);
    end
  end

endmodule

`default_nettype wire

// File: logic/join_add.sv
`timescale 1ns/100ps
`default_nettype none

module join_add (
  input  logic                clk,
  input  logic                arst_n,
  input  residual_pkg::beat_t a_data,
  input  logic                a_valid,
  output logic                a_ready,
  input  residual_pkg::beat_t b_data,
  input  logic                b_valid,
  output logic                b_ready,
  output residual_pkg::beat_t out_data,
  output logic                out_valid,
  input  logic                out_ready
);

  // both sides present and output slot free
  logic load;

  // lane-wise saturated sum
  residual_pkg::beat_t sum_data;

  assign load    = a_valid & b_valid & (~out_valid | out_ready);
  // consume both inputs together
  assign a_ready = load;
  assign b_ready = load;

  always_comb begin
    logic signed [residual_pkg::elem_w:0] sum;
    residual_pkg::elem_t                  a_lane;
    residual_pkg::elem_t                  b_lane;
    sum_data = '0;
    for (int i = 0; i < residual_pkg::lanes; i++) begin
      a_lane = a_data[i*residual_pkg::elem_w +: residual_pkg::elem_w];
      b_lane = b_data[i*residual_pkg::elem_w +: residual_pkg::elem_w];
      // one guard bit is enough for a two-term sum
      sum = $signed(a_lane) + $signed(b_lane);
      if (sum[residual_pkg::elem_w] == sum[residual_pkg::elem_w-1]) begin
        sum_data[i*residual_pkg::elem_w +: residual_pkg::elem_w] =
          sum[residual_pkg::elem_w-1:0];
      end else if (sum[residual_pkg::elem_w]) begin
        // negative overflow, pin to -128
        sum_data[i*residual_pkg::elem_w +: residual_pkg::elem_w] =
          {1'b1, {(residual_pkg::elem_w-1){1'b0}}};
      end else begin
        // positive overflow, pin to 127
        sum_data[i*residual_pkg::elem_w +: residual_pkg::elem_w] =
          {1'b0, {(residual_pkg::elem_w-1){1'b1}}};
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // output register
  always_ff @(posedge clk) begin
    if (load) out_data <= sum_data;
  end

endmodule

`default_nettype wire

// File: logic/relu_branch.sv
`timescale 1ns/100ps
`default_nettype none

module relu_branch (
  input  logic                clk,
  input  logic                arst_n,
  input  residual_pkg::beat_t in_data,
  input  logic                in_valid,
  output logic                in_ready,
  output residual_pkg::beat_t out_data,
  output logic                out_valid,
  input  logic                out_ready
);

  // stage one, raw beat
  logic                s1_valid;
  residual_pkg::beat_t s1_data;

  // stage two, rectified beat
  logic                s2_valid;
  residual_pkg::beat_t s2_data;

  // stage advance enables
  logic s1_adv;
  logic s2_adv;

  // relu of stage one contents
  residual_pkg::beat_t relu_data;

  // a stage moves when empty or when the next one moves
  assign s2_adv = ~s2_valid | out_ready;
  assign s1_adv = ~s1_valid | s2_adv;

  // stalls only with both stages full and no drain
  assign in_ready = s1_adv;

  always_comb begin
    residual_pkg::elem_t lane;
    relu_data = '0;
    for (int i = 0; i < residual_pkg::lanes; i++) begin
      lane = s1_data[i*residual_pkg::elem_w +: residual_pkg::elem_w];
      // sign bit set means negative, clamp to zero
      if (lane[residual_pkg::elem_w-1]) begin
        relu_data[i*residual_pkg::elem_w +: residual_pkg::elem_w] = '0;
      end else begin
        relu_data[i*residual_pkg::elem_w +: residual_pkg::elem_w] = lane;
      end
    end
  end

  // valid bits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_adv) s1_valid <= in_valid;
      if (s2_adv) s2_valid <= s1_valid;
    end
  end

  // payload follows the same enables
  always_ff @(posedge clk) begin
    if (s1_adv) s1_data <= in_data;
    if (s2_adv) s2_data <= relu_data;
  end

  assign out_valid = s2_valid;
  assign out_data  = s2_data;

endmodule

`default_nettype wire

// File: logic/residual_block.sv
`timescale 1ns/100ps
`default_nettype none

module residual_block (
  input  logic                clk,
  input  logic                arst_n,
  input  residual_pkg::beat_t in_data,
  input  logic                in_valid,
  output logic                in_ready,
  output residual_pkg::beat_t out_data,
  output logic                out_valid,
  input  logic                out_ready
);

  // fork to activation branch
  residual_pkg::beat_t act_data;
  logic                act_valid;
  logic                act_ready;

  // fork to skip branch
  residual_pkg::beat_t skip_data;
  logic                skip_valid;
  logic                skip_ready;

  // relu result into join
  residual_pkg::beat_t relu_data;
  logic                relu_valid;
  logic                relu_ready;

  // buffered skip beat into join
  residual_pkg::beat_t fifo_data;
  logic                fifo_valid;
  logic                fifo_ready;

  fork2 i_fork2 (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .act_data   (act_data),
    .act_valid  (act_valid),
    .act_ready  (act_ready),
    .skip_data  (skip_data),
    .skip_valid (skip_valid),
    .skip_ready (skip_ready)
  );

  relu_branch i_relu_branch (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (act_data),
    .in_valid  (act_valid),
    .in_ready  (act_ready),
    .out_data  (relu_data),
    .out_valid (relu_valid),
    .out_ready (relu_ready)
  );

  skip_fifo i_skip_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_data  (skip_data),
    .wr_valid (skip_valid),
    .wr_ready (skip_ready),
    .rd_data  (fifo_data),
    .rd_valid (fifo_valid),
    .rd_ready (fifo_ready)
  );

  // a side is relu, b side is skip
  join_add i_join_add (
    .clk       (clk),
    .arst_n    (arst_n),
    .a_data    (relu_data),
    .a_valid   (relu_valid),
    .a_ready   (relu_ready),
    .b_data    (fifo_data),
    .b_valid   (fifo_valid),
    .b_ready   (fifo_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: logic/residual_pkg.sv
`default_nettype none

package residual_pkg;

  // one lane, signed q4.3
  localparam int elem_w = 8;
  // fraction bits, neither relu nor add needs them
  localparam int elem_frac = 3;

  // lanes per beat
  localparam int lanes = 4;
  localparam int beat_w = lanes * elem_w;

  // skip buffer depth in beats
  // must cover relu latency plus one for full rate
  localparam int skip_depth = 4;

  // single lane value, read as signed
  typedef logic [elem_w-1:0] elem_t;

  // whole beat, lane i at bits i*elem_w upward
  typedef logic [beat_w-1:0] beat_t;

  // occupancy 0 .. skip_depth
  typedef logic [$clog2(skip_depth+1)-1:0] cnt_t;

endpackage

`default_nettype wire

// File: logic/skip_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module skip_fifo (
  input  logic                clk,
  input  logic                arst_n,
  input  residual_pkg::beat_t wr_data,
  input  logic                wr_valid,
  output logic                wr_ready,
  output residual_pkg::beat_t rd_data,
  output logic                rd_valid,
  input  logic                rd_ready
);

  localparam int ptr_w = $clog2(residual_pkg::skip_depth);

  // beat storage
  residual_pkg::beat_t mem [residual_pkg::skip_depth];

  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  residual_pkg::cnt_t count;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign full  = (count == residual_pkg::cnt_t'(residual_pkg::skip_depth));
  assign empty = (count == '0);

  // full still accepts when a read frees a slot this cycle
  assign wr_ready = ~full | rd_ready;
  assign rd_valid = ~empty;

  assign wr_en = wr_valid & wr_ready;
  assign rd_en = rd_valid & rd_ready;

  // head of queue
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at depth
      if (wr_en) begin
        if (wr_ptr == ptr_w'(residual_pkg::skip_depth - 1)) wr_ptr <= '0;
        else wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        if (rd_ptr == ptr_w'(residual_pkg::skip_depth - 1)) rd_ptr <= '0;
        else rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous read and write keeps count
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sim/residual_block_checker.sv
`timescale 1ns/100ps
`default_nettype none

module residual_block_checker (
  input logic                clk,
  input logic                arst_n,
  input residual_pkg::beat_t in_data,
  input logic                in_valid,
  input logic                in_ready,
  input residual_pkg::beat_t out_data,
  input logic                out_valid,
  input logic                out_ready,
  input residual_pkg::cnt_t  fifo_count
);

  // failed assertion count
  int fail_count = 0;

  // stalled input beat must stay put
  in_hold: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_data))
    else begin
      fail_count++;
      $error("input beat changed while stalled");
    end

  // output held under back-pressure
  out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      fail_count++;
      $error("output beat changed while out_ready low");
    end

  // skip fifo never overfills
  fifo_bound: assert property (@(posedge clk) disable iff (!arst_n)
    fifo_count <= residual_pkg::cnt_t'(residual_pkg::skip_depth))
    else begin
      fail_count++;
      $error("skip fifo count above depth");
    end

endmodule

bind residual_block residual_block_checker i_residual_block_checker (
  .clk        (clk),
  .arst_n     (arst_n),
  .in_data    (in_data),
  .in_valid   (in_valid),
  .in_ready   (in_ready),
  .out_data   (out_data),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .fifo_count (i_skip_fifo.count)
);

`default_nettype wire

// File: sim/residual_block_tb.sv
`timescale 1ns/100ps
`default_nettype none

module residual_block_tb;

  logic                clk;
  logic                arst_n;
  residual_pkg::beat_t in_data;
  logic                in_valid;
  logic                in_ready;
  residual_pkg::beat_t out_data;
  logic                out_valid;
  logic                out_ready;

  // stimulus columns with one entry per file line
  int                  test_q[$];
  residual_pkg::beat_t in_q[$];
  int                  code_q[$];
  residual_pkg::beat_t exp_q[$];
  int                  n_lines;
  bit                  loaded;

  int errors;
  int tests_run;
  int tests_failed;
  int seed = 32'hc194;

  residual_block i_residual_block (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #5 clk = ~clk;

  // sat8(relu(x) + x) per lane
  function automatic residual_pkg::beat_t residual_ref(input residual_pkg::beat_t x);
    residual_pkg::beat_t r;
    int                  v;
    int                  s;
    r = '0;
    for (int i = 0; i < residual_pkg::lanes; i++) begin
      v = $signed(x[i*residual_pkg::elem_w +: residual_pkg::elem_w]);
      s = (v > 0) ? v + v : v;
      if (s > 127) s = 127;
      if (s < -128) s = -128;
      r[i*residual_pkg::elem_w +: residual_pkg::elem_w] = s[7:0];
    end
    return r;
  endfunction

  // codes map to low, high or a $random bit
  function automatic logic ready_for(input int code);
    int rnd;
    if (code == 2) begin
      rnd = $random(seed);
      return rnd[0];
    end
    return (code == 1);
  endfunction

  function automatic string test_name(input int t);
    case (t)
      2: return "positive_saturate";
      3: return "negative_mixed";
      4: return "latency_throughput";
      5: return "backpressure";
      default: return $sformatf("test_%0d", t);
    endcase
  endfunction

  task automatic read_stimulus();
    int                  fd;
    int                  r;
    int                  t;
    int                  c;
    string               line;
    residual_pkg::beat_t d;
    residual_pkg::beat_t e;
    fd = $fopen("sim/residual_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/residual_stimulus.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        // comment and blank lines fail the scan
        if (r > 0 && $sscanf(line, "%d %h %d %h", t, d, c, e) == 4) begin
          if (residual_ref(d) !== e) begin
            $display("ERROR %s line %0d: expected %h, actual %h in file",
                     test_name(t), n_lines, residual_ref(d), e);
            errors++;
          end
          test_q.push_back(t);
          in_q.push_back(d);
          code_q.push_back(c);
          exp_q.push_back(e);
          n_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  // no beat sent so no output may appear
  task automatic idle_check(input string name, input int cycles);
    int err_start;
    err_start = errors;
    repeat (cycles) begin
      @(posedge clk);
      if (out_valid) begin
        $display("%s: out_valid high with no beat outstanding", name);
        errors++;
      end
      if (in_ready) begin
        $display("%s: in_ready high with no beat presented", name);
        errors++;
      end
    end
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("test %s: %s", name, (errors == err_start) ? "pass" : "fail");
  endtask

  // one test is the run of lines lo..hi
  task automatic run_test(input int lo, input int hi);
    residual_pkg::beat_t expq[$];
    residual_pkg::beat_t want;
    string               name;
    int                  idx;
    int                  cyc;
    int                  n;
    int                  n_out;
    int                  acc_cyc;
    int                  err_start;
    bit                  all_high;
    bit                  stalled;
    name      = test_name(test_q[lo]);
    n         = hi - lo + 1;
    idx       = lo;
    cyc       = 0;
    n_out     = 0;
    acc_cyc   = -1;
    err_start = errors;
    stalled   = 1'b0;
    // timing is fixed only without back-pressure
    all_high  = 1'b1;
    for (int i = lo; i <= hi; i++) begin
      if (code_q[i] != 1) all_high = 1'b0;
    end
    @(posedge clk);
    in_valid  <= 1'b1;
    in_data   <= in_q[idx];
    out_ready <= ready_for(code_q[lo]);
    while (idx <= hi || expq.size() > 0) begin
      @(posedge clk);
      cyc++;
      if (in_valid && in_ready) begin
        expq.push_back(exp_q[idx]);
        if (acc_cyc < 0) acc_cyc = cyc;
        idx++;
      end else if (in_valid) begin
        stalled = 1'b1;
      end
      if (out_valid && out_ready) begin
        if (expq.size() == 0) begin
          $display("%s: output beat %h arrived with nothing outstanding", name, out_data);
          errors++;
        end else begin
          want = expq.pop_front();
          if (out_data !== want) begin
            $display("ERROR %s: expected %h, actual %h", name, want, out_data);
            errors++;
          end
          // 3 cycle latency and then one beat per cycle
          if (all_high && cyc != acc_cyc + 3 + n_out) begin
            $display("ERROR %s: expected output cycle %0d, actual %0d",
                     name, acc_cyc + 3 + n_out, cyc);
            errors++;
          end
          n_out++;
        end
      end
      in_valid <= (idx <= hi);
      if (idx <= hi) in_data <= in_q[idx];
      out_ready <= ready_for(code_q[lo + cyc % n]);
    end
    in_valid <= 1'b0;
    if (!all_high && !stalled) begin
      $display("%s: in_ready never dropped under back-pressure", name);
      errors++;
    end
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("test %0d %s: %s, %0d beats", test_q[lo], name,
             (errors == err_start) ? "pass" : "fail", n_out);
  endtask

  initial begin
    int i;
    int lo;
    clk          = 1'b0;
    arst_n       = 1'b0;
    in_data      = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    n_lines      = 0;
    loaded       = 1'b0;
    read_stimulus();
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    idle_check("idle_after_reset", 5);
    // lines of one test sit together in the file
    i = 0;
    while (i < n_lines) begin
      lo = i;
      while (i < n_lines && test_q[i] == test_q[lo]) i++;
      run_test(lo, i - 1);
    end
    // catches duplicated beats
    idle_check("drain_check", 5);
    if (i_residual_block.i_residual_block_checker.fail_count != 0) begin
      $display("%0d handshake assertion failures in the bound checker",
               i_residual_block.i_residual_block_checker.fail_count);
      errors += i_residual_block.i_residual_block_checker.fail_count;
    end
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // budget scales with the stimulus length
  initial begin
    wait (loaded);
    repeat (n_lines * 20 + 100) @(posedge clk);
    $display("watchdog: run still busy after %0d cycles, stopping", n_lines * 20 + 100);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/residual_stimulus.txt
// test  in_beat  out_ready (0 low, 1 high, 2 random)  expected_beat
// beats in hex, lane 0 in the lowest byte
2 01020304 1 02040608
2 10203f40 1 20407e7f
2 7f7f7f7f 1 7f7f7f7f
2 00000000 1 00000000
2 5508413f 1 7f107f7e
3 80ff81f0 1 80ff81f0
3 fe02ff01 1 fe04ff02
3 7f80c040 1 7f80c07f
3 0af614ec 1 14f628ec
4 01010101 1 02020202
4 02020202 1 04040404
4 03030303 1 06060606
4 fcfcfcfc 1 fcfcfcfc
4 20e040c0 1 40e07fc0
5 11223344 0 2244667f
5 9a8b7c6d 0 9a8b7f7f
5 05f90af5 0 0af914f5
5 3080c0ff 0 6080c0ff
5 01ff01ff 2 02ff02ff
5 7e7d1f2e 1 7f7f3e5c
5 00400080 2 007f0080

// File: verilog.f
logic/residual_pkg.sv
logic/fork2.sv
logic/relu_branch.sv
logic/skip_fifo.sv
logic/join_add.sv
logic/residual_block.sv
sim/residual_block_checker.sv
sim/residual_block_tb.sv
